// File: Bender.yml
package:
  name: vec_mac

sources:
  - include_dirs:
      - common
    files:
      - common/vec_arith_pkg.sv
      - common/wb_bus_pkg.sv
      - hw/mul_lane/mul_lane.sv
      - hw/lane_dispatch.sv
      - hw/result_collect.sv
      - hw/vec_mac_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/vec_mac_props.sv
      - tb/vec_mac_tb.sv

// File: common/vec_arith_pkg.sv
`default_nettype none

package vec_arith_pkg;

    // operation applied by the collector once the products are in
    typedef enum logic [1:0] {
        OP_MUL = 2'd0,
        OP_DOT = 2'd1,
        OP_MAC = 2'd2
    } op_e;

    // code 3 has no meaning of its own and runs as a plain multiply
    function automatic op_e op_decode(input logic [1:0] code);
        op_e op;
        case (code)
            2'd1:    op = OP_DOT;
            2'd2:    op = OP_MAC;
            default: op = OP_MUL;
        endcase
        return op;
    endfunction

endpackage

`default_nettype wire

// File: common/vec_mac_defines.svh
`ifndef VEC_MAC_DEFINES_SVH
`define VEC_MAC_DEFINES_SVH

// lane count and datapath widths
`define VM_LANES      4
`define VM_WIDTH      8
`define VM_ACC_WIDTH  20

// ########################################
// word addresses on the Wishbone bus
// ########################################
`define VM_ADDR_OPND0   4'd0
`define VM_ADDR_OPND1   4'd1
`define VM_ADDR_OPND2   4'd2
`define VM_ADDR_OPND3   4'd3
`define VM_ADDR_CTRL    4'd4
`define VM_ADDR_STATUS  4'd5
`define VM_ADDR_PROD0   4'd8
`define VM_ADDR_PROD1   4'd9
`define VM_ADDR_PROD2   4'd10
`define VM_ADDR_PROD3   4'd11
`define VM_ADDR_ACC     4'd12

`endif

// File: common/wb_bus_pkg.sv
`default_nettype none

package wb_bus_pkg;

    // register class behind a bus address
    typedef enum logic [2:0] {
        SEL_OPND   = 3'd0,
        SEL_CTRL   = 3'd1,
        SEL_STATUS = 3'd2,
        SEL_PROD   = 3'd3,
        SEL_ACC    = 3'd4,
        SEL_NONE   = 3'd5
    } reg_sel_e;

    // dispatcher is either waiting for a CTRL write or has a run in flight
    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_BUSY = 1'b1
    } disp_state_e;

endpackage

`default_nettype wire

// File: hw/lane_dispatch.sv
`default_nettype none

`include "vec_mac_defines.svh"

module lane_dispatch (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               wb_cyc,
    input  logic                               wb_stb,
    input  logic                               wb_we,
    input  logic [3:0]                         wb_adr,
    input  logic [31:0]                        wb_dat_w,
    output logic [31:0]                        wb_dat_r,
    output logic                               wb_ack,
    output logic [`VM_LANES*`VM_WIDTH-1:0]     lane_a,
    output logic [`VM_LANES*`VM_WIDTH-1:0]     lane_b,
    output logic                               lane_start,
    output vec_arith_pkg::op_e                 run_op,
    input  logic                               run_done,
    input  logic [`VM_LANES*2*`VM_WIDTH-1:0]   prod_q,
    input  logic [`VM_ACC_WIDTH-1:0]           acc_q
);

    import vec_arith_pkg::*;
    import wb_bus_pkg::*;

    localparam int PW = 2 * `VM_WIDTH;

    reg_sel_e    sel;
    disp_state_e state;
    logic        req;
    logic [1:0]  idx;
    logic        done_q;
    logic        status_busy;
    logic        status_done;
    logic        start_req;
    logic        opnd_wr;

    always_comb begin
        case (wb_adr)
            `VM_ADDR_OPND0, `VM_ADDR_OPND1,
            `VM_ADDR_OPND2, `VM_ADDR_OPND3: sel = SEL_OPND;
            `VM_ADDR_CTRL:                  sel = SEL_CTRL;
            `VM_ADDR_STATUS:                sel = SEL_STATUS;
            `VM_ADDR_PROD0, `VM_ADDR_PROD1,
            `VM_ADDR_PROD2, `VM_ADDR_PROD3: sel = SEL_PROD;
            `VM_ADDR_ACC:                   sel = SEL_ACC;
            default:                        sel = SEL_NONE;
        endcase
    end

    // a request that has not been acked yet, so ack never lasts two cycles
    assign req = wb_cyc && wb_stb && !wb_ack;
    assign idx = wb_adr[1:0];

    // the finishing pulse already counts as idle, so a new run may start on it
    assign status_busy = (state == ST_BUSY) && !run_done;
    assign status_done = done_q || run_done;

    assign start_req = req && wb_we && (sel == SEL_CTRL) && !status_busy;
    assign opnd_wr   = req && wb_we && (sel == SEL_OPND) && !status_busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    // ########################################
    // run control
    // ########################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            done_q     <= 1'b0;
            lane_start <= 1'b0;
            run_op     <= OP_MUL;
        end else begin
            lane_start <= 1'b0;
            if (run_done) begin
                state  <= ST_IDLE;
                done_q <= 1'b1;
            end
            if (start_req) begin
                state      <= ST_BUSY;
                done_q     <= 1'b0;
                lane_start <= 1'b1;
                run_op     <= op_decode(wb_dat_w[1:0]);
            end
        end
    end

    // operand word is a in the low byte and b in the next one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_a <= '0;
            lane_b <= '0;
        end else if (opnd_wr) begin
            lane_a[idx*`VM_WIDTH +: `VM_WIDTH] <= wb_dat_w[`VM_WIDTH-1:0];
            lane_b[idx*`VM_WIDTH +: `VM_WIDTH] <= wb_dat_w[2*`VM_WIDTH-1:`VM_WIDTH];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_dat_r <= '0;
        end else if (req && !wb_we) begin
            case (sel)
                SEL_OPND: wb_dat_r <= 32'({lane_b[idx*`VM_WIDTH +: `VM_WIDTH],
                                           lane_a[idx*`VM_WIDTH +: `VM_WIDTH]});
                SEL_CTRL:   wb_dat_r <= 32'(run_op);
                SEL_STATUS: wb_dat_r <= 32'({status_done, status_busy});
                SEL_PROD:   wb_dat_r <= 32'(prod_q[idx*PW +: PW]);
                SEL_ACC:    wb_dat_r <= 32'(acc_q);
                default:    wb_dat_r <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/mul_lane/mul_lane.sv
`default_nettype none

module mul_lane (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [7:0]  mul_a,
    input  logic [7:0]  mul_b,
    input  logic        mul_en_in,
    output logic        mul_en_out,
    output logic [15:0] mul_out
);

    logic [2:0]  en_pipe;
    logic [7:0]  a_reg;
    logic [7:0]  b_reg;
    logic [15:0] pp [8];
    logic [15:0] pair_sum [4];
    logic [15:0] total;

    // enable travels alongside the data, three stages deep
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_pipe    <= '0;
            mul_en_out <= 1'b0;
        end else begin
            en_pipe    <= {en_pipe[1:0], mul_en_in};
            mul_en_out <= en_pipe[2];
        end
    end

    // stage 1 holds the operands until the next start
    always_ff @(posedge clk) begin
        if (mul_en_in) begin
            a_reg <= mul_a;
            b_reg <= mul_b;
        end
    end

    // each bit of b selects a shifted copy of a
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            pp[i] = b_reg[i] ? ({8'b0, a_reg} << i) : 16'd0;
        end
    end

    // ########################################
    // adder tree, pairs first then the total
    // ########################################
    always_ff @(posedge clk) begin
        for (int j = 0; j < 4; j++) begin
            pair_sum[j] <= pp[2*j] + pp[2*j+1];
        end
        total <= pair_sum[0] + pair_sum[1] + pair_sum[2] + pair_sum[3];
    end

    // output is forced to zero outside the valid cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul_out <= '0;
        end else if (en_pipe[2]) begin
            mul_out <= total;
        end else begin
            mul_out <= '0;
        end
    end

endmodule

`default_nettype wire

// File: hw/result_collect.sv
`default_nettype none

`include "vec_mac_defines.svh"

module result_collect (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [`VM_LANES*2*`VM_WIDTH-1:0]   lane_prod,
    input  logic [`VM_LANES-1:0]               lane_valid,
    input  vec_arith_pkg::op_e                 run_op,
    output logic [`VM_LANES*2*`VM_WIDTH-1:0]   prod_q,
    output logic [`VM_ACC_WIDTH-1:0]           acc_q,
    output logic                               run_done
);

    import vec_arith_pkg::*;

    localparam int PW = 2 * `VM_WIDTH;
    localparam int AW = `VM_ACC_WIDTH;

    logic          captured;
    logic [AW-1:0] prod_sum;

    // each lane lands its own product, the lanes run in lockstep anyway
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_q   <= '0;
            captured <= 1'b0;
        end else begin
            captured <= lane_valid[0];
            for (int i = 0; i < `VM_LANES; i++) begin
                if (lane_valid[i]) begin
                    prod_q[i*PW +: PW] <= lane_prod[i*PW +: PW];
                end
            end
        end
    end

    always_comb begin
        prod_sum = '0;
        for (int i = 0; i < `VM_LANES; i++) begin
            prod_sum = prod_sum + AW'(prod_q[i*PW +: PW]);
        end
    end

    // ########################################
    // accumulator, one edge after capture
    // ########################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q    <= '0;
            run_done <= 1'b0;
        end else begin
            run_done <= captured;
            if (captured) begin
                case (run_op)
                    OP_DOT:  acc_q <= prod_sum;
                    OP_MAC:  acc_q <= acc_q + prod_sum;
                    default: acc_q <= acc_q;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/vec_mac_top.sv
`default_nettype none

`include "vec_mac_defines.svh"

module vec_mac_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [3:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack
);

    import vec_arith_pkg::*;

    localparam int PW = 2 * `VM_WIDTH;

    logic [`VM_LANES*`VM_WIDTH-1:0] lane_a;
    logic [`VM_LANES*`VM_WIDTH-1:0] lane_b;
    logic                           lane_start;
    logic [`VM_LANES*PW-1:0]        lane_prod;
    logic [`VM_LANES-1:0]           lane_valid;
    op_e                            run_op;
    logic                           run_done;
    logic [`VM_LANES*PW-1:0]        prod_q;
    logic [`VM_ACC_WIDTH-1:0]       acc_q;

    lane_dispatch u_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .lane_a     (lane_a),
        .lane_b     (lane_b),
        .lane_start (lane_start),
        .run_op     (run_op),
        .run_done   (run_done),
        .prod_q     (prod_q),
        .acc_q      (acc_q)
    );

    // all lanes share one start pulse
    for (genvar i = 0; i < `VM_LANES; i++) begin : g_lane
        mul_lane u_lane (
            .clk        (clk),
            .rst_n      (rst_n),
            .mul_a      (lane_a[i*`VM_WIDTH +: `VM_WIDTH]),
            .mul_b      (lane_b[i*`VM_WIDTH +: `VM_WIDTH]),
            .mul_en_in  (lane_start),
            .mul_en_out (lane_valid[i]),
            .mul_out    (lane_prod[i*PW +: PW])
        );
    end

    result_collect u_collect (
        .clk        (clk),
        .rst_n      (rst_n),
        .lane_prod  (lane_prod),
        .lane_valid (lane_valid),
        .run_op     (run_op),
        .prod_q     (prod_q),
        .acc_q      (acc_q),
        .run_done   (run_done)
    );

endmodule

`default_nettype wire

// File: tb/vec_mac_props.sv
`default_nettype none

`include "vec_mac_defines.svh"

module vec_mac_props (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    wb_cyc,
    input logic                    wb_stb,
    input logic                    wb_ack,
    input logic                    lane_start,
    input logic [`VM_LANES-1:0]    lane_valid,
    input logic                    run_done,
    input wb_bus_pkg::disp_state_e disp_state
);

    import wb_bus_pkg::*;

    int fail_count = 0;

    // ########################################
    // Wishbone handshake
    // ########################################
    ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
    else begin
        fail_count++;
        $error("wb_ack stayed high for two cycles");
    end

    ack_in_request: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> (wb_cyc && wb_stb))
    else begin
        fail_count++;
        $error("wb_ack came without a bus request");
    end

    // ########################################
    // lane pipeline and run timing
    // ########################################
    valid_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        lane_start |-> ##4 (&lane_valid))
    else begin
        fail_count++;
        $error("lane_valid did not follow lane_start by 4 cycles");
    end

    valid_has_start: assert property (@(posedge clk) disable iff (!rst_n)
        (|lane_valid) |-> $past(lane_start, 4))
    else begin
        fail_count++;
        $error("lane_valid rose without a start 4 cycles earlier");
    end

    // the done pulse ends the run, unless a new start lands right on it
    done_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        lane_start |-> (disp_state == ST_BUSY) ##6 run_done)
    else begin
        fail_count++;
        $error("run_done did not arrive 6 cycles after the start");
    end

    idle_after_done: assert property (@(posedge clk) disable iff (!rst_n)
        run_done |=> (disp_state == ST_IDLE) || lane_start)
    else begin
        fail_count++;
        $error("dispatcher stayed busy after run_done");
    end

endmodule

bind vec_mac_top vec_mac_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_ack     (wb_ack),
    .lane_start (lane_start),
    .lane_valid (lane_valid),
    .run_done   (run_done),
    .disp_state (u_dispatch.state)
);

`default_nettype wire

// File: tb/vec_mac_tb.sv
`default_nettype none

`include "vec_mac_defines.svh"

module vec_mac_tb;

    import vec_arith_pkg::*;

    // about 200 bus transfers, none of them longer than 10 cycles
    localparam int XFER_LIMIT     = 200;
    localparam int XFER_CYCLES    = 10;
    localparam int TIMEOUT_CYCLES = XFER_LIMIT * XFER_CYCLES;
    localparam int AW             = `VM_ACC_WIDTH;

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    int          cnt = 0;
    int          ack_cnt;
    logic [7:0]  exp_a [`VM_LANES];
    logic [7:0]  exp_b [`VM_LANES];
    logic [AW-1:0] exp_acc;

    vec_mac_top DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cnt <= cnt + 1;
    end

    always @(negedge clk) begin
        if (DUT.u_props.fail_count != 0) begin
            $display("a bound protocol assertion failed, see the error above");
            $display("** FAIL **");
            $fatal(1);
        end else if (cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the test sequence did not finish in %0d cycles", cnt);
            $display("** FAIL **");
            $fatal(1);
        end
    end

    // ########################################
    // bus tasks
    // ########################################
    task automatic bus_cycle(input logic we, input logic [3:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        do begin
            @(negedge clk);
        end while (!wb_ack);
        rdata   = wb_dat_r;
        ack_cnt = cnt;
        // strobe stays up until the edge that closes the ack cycle
        @(negedge clk);
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_dat_w = '0;
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [31:0] data);
        logic [31:0] ignored;
        bus_cycle(1'b1, adr, data, ignored);
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [31:0] data);
        bus_cycle(1'b0, adr, '0, data);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        assert (act_val === exp_val) else begin
            $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, exp_val, act_val);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic randomize_operands();
        for (int i = 0; i < `VM_LANES; i++) begin
            exp_a[i] = 8'($urandom);
            exp_b[i] = 8'($urandom);
        end
    endtask

    task automatic load_operands();
        for (int i = 0; i < `VM_LANES; i++) begin
            wb_write(4'(`VM_ADDR_OPND0 + i), {16'h0, exp_b[i], exp_a[i]});
        end
    endtask

    // starts a run, polls STATUS until done and updates the model accumulator
    task automatic start_run(input logic [1:0] code, input int skew, input bit intrude);
        int          c0;
        int          v;
        logic [31:0] status;
        logic [AW-1:0] sum;
        wb_write(`VM_ADDR_CTRL, 32'(code));
        c0 = ack_cnt;
        if (intrude) begin
            wb_write(`VM_ADDR_OPND0, {16'h0, ~exp_b[0], ~exp_a[0]});
            wb_write(`VM_ADDR_CTRL, (code == OP_DOT) ? 32'(OP_MAC) : 32'(OP_DOT));
        end
        repeat (skew) @(negedge clk);
        do begin
            wb_read(`VM_ADDR_STATUS, status);
            // read data shows the cycle before its ack, counted from the CTRL ack
            v = ack_cnt - 1 - c0;
            check_value($sformatf("status %0d cycles after start", v),
                        {30'h0, v >= 6, v < 6}, status);
        end while (!status[1]);
        sum = '0;
        for (int i = 0; i < `VM_LANES; i++) begin
            sum = sum + AW'(16'(exp_a[i]) * 16'(exp_b[i]));
        end
        if (code == OP_DOT) begin
            exp_acc = sum;
        end else if (code == OP_MAC) begin
            exp_acc = exp_acc + sum;
        end
    endtask

    task automatic check_results(input string name);
        logic [31:0] data;
        for (int i = 0; i < `VM_LANES; i++) begin
            wb_read(4'(`VM_ADDR_PROD0 + i), data);
            check_value($sformatf("%s prod%0d", name, i),
                        32'(16'(exp_a[i]) * 16'(exp_b[i])), data);
        end
        wb_read(`VM_ADDR_ACC, data);
        check_value({name, " acc"}, 32'(exp_acc), data);
    endtask

    // ########################################
    // test sequence
    // ########################################
    initial begin
        logic [31:0] data;
        logic [3:0]  hole;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        exp_acc  = '0;
        void'($urandom(27));
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        wb_read(`VM_ADDR_STATUS, data);
        check_value("reset status", 32'h0, data);
        for (int i = 0; i < `VM_LANES; i++) begin
            exp_a[i] = '0;
            exp_b[i] = '0;
        end
        check_results("reset");

        // unmapped addresses are acked and read as zero
        wb_write(4'd14, 32'hdead_beef);
        for (int i = 0; i < 5; i++) begin
            hole = (i < 2) ? 4'(6 + i) : 4'(11 + i);
            wb_read(hole, data);
            check_value($sformatf("unmapped read 0x%0h", hole), 32'h0, data);
        end

        for (int r = 0; r < 3; r++) begin
            randomize_operands();
            load_operands();
            start_run(OP_MUL, r % 2, 1'b0);
            check_results($sformatf("mul_rand%0d", r));
        end

        randomize_operands();
        exp_a[0] = 8'd0;
        exp_b[1] = 8'd0;
        for (int i = 2; i < `VM_LANES; i++) begin
            exp_a[i] = 8'd255;
            exp_b[i] = 8'd255;
        end
        load_operands();
        start_run(OP_MUL, 1, 1'b0);
        check_results("mul_corner");

        for (int r = 0; r < 3; r++) begin
            randomize_operands();
            load_operands();
            start_run((r == 0) ? OP_DOT : OP_MAC, r % 2, 1'b0);
            check_results($sformatf("dot_mac%0d", r));
        end

        // full-scale sums wrap the accumulator on the fifth run
        for (int i = 0; i < `VM_LANES; i++) begin
            exp_a[i] = 8'd255;
            exp_b[i] = 8'd255;
        end
        load_operands();
        for (int r = 0; r < 5; r++) begin
            start_run((r == 0) ? OP_DOT : OP_MAC, r % 2, 1'b0);
            check_results($sformatf("acc_wrap%0d", r));
        end

        randomize_operands();
        load_operands();
        start_run(OP_MUL, 0, 1'b1);
        check_results("busy_ignore");
        // the lanes latched their operands before the blocked write, so rerun to expose it
        start_run(OP_MUL, 1, 1'b0);
        check_results("busy_rerun");

        randomize_operands();
        load_operands();
        start_run(2'd3, 1, 1'b0);
        check_results("opcode3_mul");

        repeat (8) @(negedge clk);
        if (DUT.u_props.fail_count == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("** FAIL **");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// File: vec_mac.f
+incdir+common
common/vec_arith_pkg.sv
common/wb_bus_pkg.sv
hw/mul_lane/mul_lane.sv
hw/lane_dispatch.sv
hw/result_collect.sv
hw/vec_mac_top.sv
tb/vec_mac_props.sv
tb/vec_mac_tb.sv
